// File: rtl/dmm_cfg.svh
// build constants for the dmm control fpga
// widths, spi register map, status magic and test pattern divider
// pull in with `include wherever a macro is referenced
`ifndef DMM_CFG_SVH
`define DMM_CFG_SVH

////////////////////
// widths

`define DMM_REG_W          32     // spi register word
`define DMM_ADDR_W         7      // address bits after the write flag
`define DMM_COUNT_W        24     // clk counts, precharge and aperture
`define DMM_SEQ_W          6      // azmux + pc_sw per sequence entry
`define DMM_SEQ_MAX        4
`define DMM_OUT_W          26     // board output vector

`define DMM_MAGIC          8'hAA  // status low byte, spi sanity check
`define DMM_PATTERN_SHIFT  4      // test pattern lsb toggles every 2^4 clks
`define DMM_SYNC_STAGES    2      // pin synchronizer depth

////////////////////
// register map

`define REG_MODE           7'd0
`define REG_DIRECT         7'd1
`define REG_SPI_MUX        7'd2
`define REG_4094           7'd3
`define REG_STATUS         7'd4   // read only
`define REG_SA_PRECHARGE   7'd5
`define REG_SA_SEQ_N       7'd6
`define REG_SA_SEQ0        7'd7
`define REG_SA_SEQ1        7'd8
`define REG_SA_SEQ2        7'd9
`define REG_SA_SEQ3        7'd10
`define REG_ADC_APERTURE   7'd11

`endif

// File: rtl/dmm_pkg.sv
// types shared by the dmm control blocks
// the output vector struct is the bit order of the direct register
// and of every mode source feeding the pin mux

`include "dmm_cfg.svh"

package dmm_pkg;

  typedef logic [`DMM_REG_W-1:0]   reg_word_t;
  typedef logic [`DMM_COUNT_W-1:0] count_t;
  typedef logic [`DMM_SEQ_W-1:0]   seq_word_t;  // [5:4] pc_sw, [3:0] azmux
  typedef logic [1:0]              seq_idx_t;
  typedef logic [2:0]              mode_sel_t;
  typedef logic [3:0]              hw_flags_t;

  // msb first, 26 bits total
  typedef struct packed {
    logic       adc_reset_n;    // not pinned out
    logic       meas_complete;
    logic       spi_interrupt;
    logic       cmpr_latch;
    logic [3:0] adc_refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_vec_t;

  typedef struct packed {
    count_t                         precharge;  // clks held per word, minus one
    logic [2:0]                     seq_n;      // clamped to 1..4 by the user
    seq_word_t [`DMM_SEQ_MAX-1:0]   seq;
  } seq_cfg_t;

endpackage

// File: rtl/spi_reg_bank.sv
// spi slave and register file, all in the CLK domain
// SCK, SS and SDI are oversampled so SCK half periods need 4+ clks
// frame is 40 bits msb first: {wr, addr[6:0]} then 32 data bits
// readback shifts out on SDO from bit 8 on, writes commit at SS rise

`timescale 1ns/1ps
`include "dmm_cfg.svh"

module spi_reg_bank (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                sck_i,
  input  logic                ss_n_i,
  input  logic                sdi_i,
  input  dmm_pkg::hw_flags_t  hw_flags_i,
  input  dmm_pkg::seq_idx_t   sample_idx_last_i,
  output logic                sdo_o,
  output dmm_pkg::mode_sel_t  mode_o,
  output dmm_pkg::out_vec_t   direct_o,
  output logic [1:0]          spi_mux_o,
  output logic                oe_4094_o,
  output dmm_pkg::seq_cfg_t   seq_cfg_o,
  output dmm_pkg::count_t     aperture_o
);
  import dmm_pkg::*;

  localparam int FRAME_BITS = 8 + `DMM_REG_W;

  logic [`DMM_SYNC_STAGES:0]   sck_sr, ss_sr;   // extra top stage for edges
  logic [`DMM_SYNC_STAGES-1:0] sdi_sr;
  logic       sck_rise, sck_fall, ss_rise, ss_fall, ss_low, sdi_s;
  logic [5:0] bit_cnt_q;    // saturates one past a full frame
  logic [7:0] cmd_q;        // wr flag + address
  reg_word_t  rx_q, rx_next, tx_q, rd_word;

  mode_sel_t  mode_q;
  out_vec_t   direct_q;
  logic [1:0] spi_mux_q;
  logic       oe_4094_q;
  seq_cfg_t   cfg_q;
  count_t     aperture_q;

  ////////////////////
  // pin sync + edges

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sck_sr <= '0;
      ss_sr  <= '1;   // deselected
      sdi_sr <= '0;
    end else begin
      sck_sr <= {sck_sr[`DMM_SYNC_STAGES-1:0], sck_i};
      ss_sr  <= {ss_sr[`DMM_SYNC_STAGES-1:0], ss_n_i};
      sdi_sr <= {sdi_sr[`DMM_SYNC_STAGES-2:0], sdi_i};
    end
  end

  assign sck_rise = sck_sr[`DMM_SYNC_STAGES-1] & ~sck_sr[`DMM_SYNC_STAGES];
  assign sck_fall = ~sck_sr[`DMM_SYNC_STAGES-1] & sck_sr[`DMM_SYNC_STAGES];
  assign ss_rise  = ss_sr[`DMM_SYNC_STAGES-1] & ~ss_sr[`DMM_SYNC_STAGES];
  assign ss_fall  = ~ss_sr[`DMM_SYNC_STAGES-1] & ss_sr[`DMM_SYNC_STAGES];
  assign ss_low   = ~ss_sr[`DMM_SYNC_STAGES-1];
  assign sdi_s    = sdi_sr[`DMM_SYNC_STAGES-1];   // same delay as sck
  assign rx_next  = {rx_q[`DMM_REG_W-2:0], sdi_s};

  ////////////////////
  // shift in / out

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
    end else if (ss_fall) begin
      bit_cnt_q <= '0;
    end else if (ss_low && sck_rise && bit_cnt_q <= FRAME_BITS) begin
      bit_cnt_q <= bit_cnt_q + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (ss_fall) begin
      tx_q <= '0;
    end else if (ss_low && sck_rise) begin
      rx_q <= rx_next;
      if (bit_cnt_q == 6'd7)
        cmd_q <= rx_next[7:0];    // 8th bit completes the command byte
    end else if (ss_low && sck_fall) begin
      if (bit_cnt_q == 6'd8)
        tx_q <= rd_word;          // first data bit goes out on this fall
      else if (bit_cnt_q > 6'd8)
        tx_q <= {tx_q[`DMM_REG_W-2:0], 1'b0};
    end
  end

  assign sdo_o = ~ss_n_i & tx_q[`DMM_REG_W-1];  // quiet while deselected

  // readback mux, zero extended
  always_comb begin
    rd_word = '0;
    case (cmd_q[`DMM_ADDR_W-1:0])
      `REG_MODE:         rd_word = reg_word_t'(mode_q);
      `REG_DIRECT:       rd_word = reg_word_t'(direct_q);
      `REG_SPI_MUX:      rd_word = reg_word_t'(spi_mux_q);
      `REG_4094:         rd_word = reg_word_t'(oe_4094_q);
      `REG_STATUS:       rd_word = {9'b0, cfg_q.seq_n, 2'b0, sample_idx_last_i,
                                    2'b0, spi_mux_q, hw_flags_i, `DMM_MAGIC};
      `REG_SA_PRECHARGE: rd_word = reg_word_t'(cfg_q.precharge);
      `REG_SA_SEQ_N:     rd_word = reg_word_t'(cfg_q.seq_n);
      `REG_SA_SEQ0:      rd_word = reg_word_t'(cfg_q.seq[0]);
      `REG_SA_SEQ1:      rd_word = reg_word_t'(cfg_q.seq[1]);
      `REG_SA_SEQ2:      rd_word = reg_word_t'(cfg_q.seq[2]);
      `REG_SA_SEQ3:      rd_word = reg_word_t'(cfg_q.seq[3]);
      `REG_ADC_APERTURE: rd_word = reg_word_t'(aperture_q);
      default:           rd_word = '0;
    endcase
  end

  ////////////////////
  // register file

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mode_q     <= '0;
      direct_q   <= '0;
      spi_mux_q  <= '0;
      oe_4094_q  <= 1'b0;   // 4094 outputs off at power up
      cfg_q      <= '0;
      aperture_q <= '0;
    end else if (ss_rise && bit_cnt_q == FRAME_BITS && cmd_q[7]) begin
      case (cmd_q[`DMM_ADDR_W-1:0])
        `REG_MODE:         mode_q          <= rx_q[2:0];
        `REG_DIRECT:       direct_q        <= rx_q[`DMM_OUT_W-1:0];
        `REG_SPI_MUX:      spi_mux_q       <= rx_q[1:0];
        `REG_4094:         oe_4094_q       <= rx_q[0];
        `REG_SA_PRECHARGE: cfg_q.precharge <= rx_q[`DMM_COUNT_W-1:0];
        `REG_SA_SEQ_N:     cfg_q.seq_n     <= rx_q[2:0];
        `REG_SA_SEQ0:      cfg_q.seq[0]    <= rx_q[`DMM_SEQ_W-1:0];
        `REG_SA_SEQ1:      cfg_q.seq[1]    <= rx_q[`DMM_SEQ_W-1:0];
        `REG_SA_SEQ2:      cfg_q.seq[2]    <= rx_q[`DMM_SEQ_W-1:0];
        `REG_SA_SEQ3:      cfg_q.seq[3]    <= rx_q[`DMM_SEQ_W-1:0];
        `REG_ADC_APERTURE: aperture_q      <= rx_q[`DMM_COUNT_W-1:0];
        default: ;        // status and unmapped ignore writes
      endcase
    end
  end

  assign mode_o     = mode_q;
  assign direct_o   = direct_q;
  assign spi_mux_o  = spi_mux_q;
  assign oe_4094_o  = oe_4094_q;
  assign seq_cfg_o  = cfg_q;
  assign aperture_o = aperture_q;

  // overlong frames park the counter instead of wrapping
  a_bit_cnt_sat: assert property (@(posedge clk) disable iff (!rst_n_i)
    bit_cnt_q <= FRAME_BITS + 1);

  // register outputs only move right after a deselect
  a_write_on_ss: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$stable({mode_q, direct_q, spi_mux_q, oe_4094_q, cfg_q, aperture_q})
      |-> $past(ss_rise));

endmodule

// File: rtl/adc_mock.sv
// stand-in for the modulation adc
// counts the aperture once released from reset, then fires one valid
// pulse and idles until the next reset, so switch timing can be
// exercised on a board without the adc populated

`timescale 1ns/1ps

module adc_mock (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             adc_reset_n_i,
  input  dmm_pkg::count_t  aperture_i,
  output logic             meas_valid_o
);
  import dmm_pkg::*;

  count_t cnt_q;
  logic   done_q;   // pulse sent, wait for reset

  always_ff @(posedge clk) begin
    if (!rst_n_i || !adc_reset_n_i) begin
      cnt_q        <= '0;
      done_q       <= 1'b0;
      meas_valid_o <= 1'b0;
    end else begin
      meas_valid_o <= 1'b0;
      if (!done_q) begin
        if (cnt_q == aperture_i) begin
          meas_valid_o <= 1'b1;   // aperture+1 clks after release
          done_q       <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    meas_valid_o |=> !meas_valid_o);

endmodule

// File: rtl/sequence_acq.sv
// sample sequence controller
// while armed, walks the azmux/pc_sw words: precharge for a
// programmed time with the adc held in reset, then release the adc
// and wait for its valid pulse before moving to the next word

`timescale 1ns/1ps

module sequence_acq (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                arm_i,
  input  logic                meas_valid_i,
  input  dmm_pkg::seq_cfg_t   cfg_i,
  output logic                adc_reset_n_o,
  output dmm_pkg::seq_idx_t   sample_idx_last_o,
  output dmm_pkg::out_vec_t   sa_vec_o
);
  import dmm_pkg::*;

  typedef enum logic [1:0] {IDLE, PRECHARGE, ACQUIRE} sa_state_t;

  sa_state_t  state_q;
  logic [1:0] arm_sr;         // arm is a plain level from the mcu
  logic       arm_s;
  count_t     cnt_q;
  seq_idx_t   idx_q;
  logic [2:0] seq_n_eff, idx_inc;
  seq_word_t  word;

  assign arm_s = arm_sr[1];

  // 0 behaves as 1, anything past 4 as 4
  assign seq_n_eff = (cfg_i.seq_n == 3'd0) ? 3'd1 :
                     (cfg_i.seq_n > 3'd4)  ? 3'd4 : cfg_i.seq_n;
  assign idx_inc   = {1'b0, idx_q} + 3'd1;
  assign word      = cfg_i.seq[idx_q];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      arm_sr            <= '0;
      state_q           <= IDLE;
      cnt_q             <= '0;
      idx_q             <= '0;
      sample_idx_last_o <= '0;
    end else begin
      arm_sr <= {arm_sr[0], arm_i};
      if (!arm_s) begin
        state_q <= IDLE;
        idx_q   <= '0;
      end else begin
        case (state_q)
          IDLE: begin
            state_q <= PRECHARGE;
            cnt_q   <= '0;
          end
          PRECHARGE: begin    // precharge+1 clks on this word
            if (cnt_q == cfg_i.precharge)
              state_q <= ACQUIRE;
            else
              cnt_q <= cnt_q + 1'b1;
          end
          ACQUIRE: begin
            if (meas_valid_i) begin
              sample_idx_last_o <= idx_q;
              idx_q   <= (idx_inc >= seq_n_eff) ? seq_idx_t'(0) : idx_inc[1:0];
              state_q <= PRECHARGE;
              cnt_q   <= '0;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  assign adc_reset_n_o = (state_q == ACQUIRE);

  always_comb begin
    sa_vec_o         = '0;
    sa_vec_o.azmux   = word[3:0];
    sa_vec_o.pc_sw   = word[5:4];
    sa_vec_o.monitor = {4'b0, idx_q, meas_valid_i, adc_reset_n_o};
    sa_vec_o.leds[0] = arm_s;
  end

  // index never points past the clamped sequence
  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    ({1'b0, idx_q} < seq_n_eff));

endmodule

// File: rtl/pin_mux.sv
// output mode select and shared spi pin routing
// mode 0 direct register, 3 test pattern, 6 sequence with mocked adc,
// all other modes hold every output low
// spi_mux steers SCK/SDI/CS2 to the 4094 chain or the dac

`timescale 1ns/1ps
`include "dmm_cfg.svh"

module pin_mux (
  input  logic                clk,
  input  logic                rst_n_i,
  input  dmm_pkg::mode_sel_t  mode_i,
  input  dmm_pkg::out_vec_t   direct_i,
  input  dmm_pkg::out_vec_t   sa_vec_i,
  input  logic [1:0]          spi_mux_i,
  input  logic                sck_i,
  input  logic                sdi_i,
  input  logic                spi_cs2_i,
  output dmm_pkg::out_vec_t   out_o,
  output logic                glb_spi_clk_o,
  output logic                glb_spi_mosi_o,
  output logic                glb_4094_strobe_o,
  output logic                spi_dac_ss_o
);
  import dmm_pkg::*;

  localparam mode_sel_t MODE_DIRECT  = 3'd0;
  localparam mode_sel_t MODE_PATTERN = 3'd3;
  localparam mode_sel_t MODE_SA_MOCK = 3'd6;

  logic [`DMM_OUT_W+`DMM_PATTERN_SHIFT-1:0] pat_cnt_q;  // free running
  out_vec_t pattern;

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      pat_cnt_q <= '0;
    else
      pat_cnt_q <= pat_cnt_q + 1'b1;
  end

  // bit k toggles every 2^(shift+k) clks, leds[0] fastest
  assign pattern = pat_cnt_q[`DMM_OUT_W+`DMM_PATTERN_SHIFT-1 -: `DMM_OUT_W];

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  out_o = direct_i;
      MODE_PATTERN: out_o = pattern;
      MODE_SA_MOCK: out_o = sa_vec_i;
      default:      out_o = '0;
    endcase
  end

  ////////////////////
  // spi routing

  assign glb_spi_clk_o     = (spi_mux_i == 2'd0) ? 1'b1 : sck_i;   // park hi
  assign glb_spi_mosi_o    = (spi_mux_i == 2'd0) ? 1'b1 : sdi_i;
  assign glb_4094_strobe_o = (spi_mux_i == 2'd1) ? ~spi_cs2_i : 1'b0; // active hi
  assign spi_dac_ss_o      = (spi_mux_i == 2'd2) ? spi_cs2_i : 1'b1;  // active lo

  a_unused_low: assert property (@(posedge clk) disable iff (!rst_n_i)
    (mode_i inside {3'd1, 3'd2, 3'd4, 3'd5, 3'd7}) |-> (out_o == '0));

endmodule

// File: rtl/dmm_top.sv
// top level of the dmm front end control fpga
// spi register bank sets the mode, direct outputs and the sequence
// config; sequence controller runs against the mocked adc and the
// pin mux picks which source owns the board outputs

`timescale 1ns/1ps

module dmm_top (
  input  logic               CLK,
  input  logic               rst_n_i,
  input  logic               SCK,
  input  logic               SS,
  input  logic               SDI,
  input  logic               SPI_CS2,
  input  logic               trigger_source_internal_i,   // arm level
  input  dmm_pkg::hw_flags_t hw_flags_i,
  output logic               SDO,
  output logic [3:0]         leds_o,
  output logic [7:0]         monitor_o,
  output logic [1:0]         pc_sw_o,
  output logic [3:0]         azmux_o,
  output logic [3:0]         adc_refmux_o,
  output logic               adc_cmpr_latch_ctl_o,
  output logic               spi_interrupt_ctl_o,
  output logic               meas_complete_o,
  output logic               GLB_SPI_MOSI,
  output logic               GLB_SPI_CLK,
  output logic               GLB_4094_OE_CTL,
  output logic               GLB_4094_STROBE_CTL,
  output logic               SPI_DAC_SS
);
  import dmm_pkg::*;

  mode_sel_t  mode;
  out_vec_t   direct, sa_vec, out_vec;
  logic [1:0] spi_mux;
  seq_cfg_t   seq_cfg;
  count_t     aperture;
  seq_idx_t   sample_idx_last;
  logic       adc_reset_n, meas_valid;

  spi_reg_bank u_spi_reg_bank (
    .clk               (CLK),
    .rst_n_i           (rst_n_i),
    .sck_i             (SCK),
    .ss_n_i            (SS),
    .sdi_i             (SDI),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .sdo_o             (SDO),
    .mode_o            (mode),
    .direct_o          (direct),
    .spi_mux_o         (spi_mux),
    .oe_4094_o         (GLB_4094_OE_CTL),   // straight to the pin
    .seq_cfg_o         (seq_cfg),
    .aperture_o        (aperture)
  );

  adc_mock u_adc_mock (
    .clk           (CLK),
    .rst_n_i       (rst_n_i),
    .adc_reset_n_i (adc_reset_n),
    .aperture_i    (aperture),
    .meas_valid_o  (meas_valid)
  );

  sequence_acq u_sequence_acq (
    .clk               (CLK),
    .rst_n_i           (rst_n_i),
    .arm_i             (trigger_source_internal_i),
    .meas_valid_i      (meas_valid),
    .cfg_i             (seq_cfg),
    .adc_reset_n_o     (adc_reset_n),
    .sample_idx_last_o (sample_idx_last),
    .sa_vec_o          (sa_vec)
  );

  pin_mux u_pin_mux (
    .clk               (CLK),
    .rst_n_i           (rst_n_i),
    .mode_i            (mode),
    .direct_i          (direct),
    .sa_vec_i          (sa_vec),
    .spi_mux_i         (spi_mux),
    .sck_i             (SCK),
    .sdi_i             (SDI),
    .spi_cs2_i         (SPI_CS2),
    .out_o             (out_vec),
    .glb_spi_clk_o     (GLB_SPI_CLK),
    .glb_spi_mosi_o    (GLB_SPI_MOSI),
    .glb_4094_strobe_o (GLB_4094_STROBE_CTL),
    .spi_dac_ss_o      (SPI_DAC_SS)
  );

  ////////////////////
  // split onto pins, adc_reset_n has no pin

  assign meas_complete_o      = out_vec.meas_complete;
  assign spi_interrupt_ctl_o  = out_vec.spi_interrupt;
  assign adc_cmpr_latch_ctl_o = out_vec.cmpr_latch;
  assign adc_refmux_o         = out_vec.adc_refmux;
  assign azmux_o              = out_vec.azmux;
  assign pc_sw_o              = out_vec.pc_sw;
  assign monitor_o            = out_vec.monitor;
  assign leds_o               = out_vec.leds;

endmodule

// File: verif/tb_top.sv
// directed testbench for the dmm control fpga top level
// bit-bangs frames into the spi register bank, then checks reset state,
// readback, direct mode, spi pin routing, unused modes, the test pattern
// and the sample sequencer running against the mocked adc
// one line per test, counts and the verdict at the end

`timescale 1ns/1ps
`include "dmm_cfg.svh"

module tb_top;
  import dmm_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DLY   = 10;      // inputs move this long after posedge
  localparam int HALF_CYC    = 4;       // sck half period in clks
  localparam int FRAME_BITS  = 8 + `DMM_REG_W;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_BUDGET = 20000;   // clks per test
  localparam int PULSE_WAIT  = 400;     // clks allowed per measurement
  localparam logic [31:0] SEED = 32'h3eeaa72c;

  logic       clk, rst_n, sck, ss, sdi, spi_cs2, arm;
  hw_flags_t  hw_flags;
  logic       sdo, cmpr_latch, spi_int, meas_complete;
  logic [3:0] leds, azmux, refmux;
  logic [7:0] monitor;
  logic [1:0] pc_sw;
  logic       glb_mosi, glb_clk, glb_oe, glb_strobe, dac_ss;
  out_vec_t   pins;       // pins packed back into the output struct
  int         err_cnt, tests_run, tests_passed, tests_failed;

  dmm_top DUT (
    .CLK (clk), .rst_n_i (rst_n), .SCK (sck), .SS (ss), .SDI (sdi),
    .SPI_CS2 (spi_cs2), .trigger_source_internal_i (arm), .hw_flags_i (hw_flags),
    .SDO (sdo), .leds_o (leds), .monitor_o (monitor), .pc_sw_o (pc_sw),
    .azmux_o (azmux), .adc_refmux_o (refmux), .adc_cmpr_latch_ctl_o (cmpr_latch),
    .spi_interrupt_ctl_o (spi_int), .meas_complete_o (meas_complete),
    .GLB_SPI_MOSI (glb_mosi), .GLB_SPI_CLK (glb_clk), .GLB_4094_OE_CTL (glb_oe),
    .GLB_4094_STROBE_CTL (glb_strobe), .SPI_DAC_SS (dac_ss)
  );

  // adc_reset_n has no pin, reads as 0
  assign pins = {1'b0, meas_complete, spi_int, cmpr_latch, refmux, azmux,
                 pc_sw, monitor, leds};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // compare tasks

  task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_vec(input string name, input out_vec_t exp, input out_vec_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_idx(input string name, input seq_idx_t exp, input seq_idx_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////
  // helpers

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #(DRIVE_DLY);
    end
  endtask

  // status layout: magic, flags, mux, last index, seq_n
  function automatic reg_word_t expected_status(input hw_flags_t hw, input logic [1:0] mux,
                                                input seq_idx_t idx, input logic [2:0] seq_n);
    reg_word_t w;
    w        = '0;
    w[7:0]   = `DMM_MAGIC;
    w[11:8]  = hw;
    w[15:12] = {2'b00, mux};
    w[17:16] = idx;
    w[22:20] = seq_n;
    return w;
  endfunction

  // one frame of nbits, msb first, sdo sampled at the end of each low half
  task automatic send_frame(input logic [7:0] cmd, input reg_word_t wdata,
                            input int nbits, output reg_word_t rdata);
    logic [39:0] frame;
    int          b;
    frame = {cmd, wdata};
    rdata = '0;
    ss    = 1'b0;
    wait_cycles(HALF_CYC);    // let the slave see ss fall
    for (b = 0; b < nbits; b++) begin
      sck = 1'b0;
      sdi = (b < FRAME_BITS) ? frame[39-b] : 1'b0;
      wait_cycles(HALF_CYC);
      if (b >= 8 && b < FRAME_BITS)
        rdata[39-b] = sdo;
      sck = 1'b1;             // slave samples on this rise
      wait_cycles(HALF_CYC);
    end
    ss = 1'b1;
    wait_cycles(8);           // sync + edge detect before commit
  endtask

  task automatic spi_write(input logic [6:0] addr, input reg_word_t data);
    reg_word_t unused_rd;
    send_frame({1'b1, addr}, data, FRAME_BITS, unused_rd);
  endtask

  task automatic spi_read(input logic [6:0] addr, output reg_word_t data);
    send_frame({1'b0, addr}, '0, FRAME_BITS, data);
  endtask

  // random write, readback masked to the register width
  task automatic write_and_verify(input logic [6:0] addr, input int width,
                                  input string name, output reg_word_t kept);
    reg_word_t wr, rd;
    wr   = $urandom();
    kept = (width >= 32) ? wr : (wr & ((32'd1 << width) - 32'd1));
    spi_write(addr, wr);
    spi_read(addr, rd);
    check_word(name, kept, rd);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  ////////////////////
  // tests

  task automatic reset_and_readback();
    int        errs;
    reg_word_t rd, kept, seq_n;
    errs = err_cnt;
    check_vec("output pins", '0, pins);
    check_bit("GLB_SPI_CLK", 1'b1, glb_clk);      // parked high
    check_bit("GLB_SPI_MOSI", 1'b1, glb_mosi);
    check_bit("SPI_DAC_SS", 1'b1, dac_ss);
    check_bit("GLB_4094_OE_CTL", 1'b0, glb_oe);
    check_bit("GLB_4094_STROBE_CTL", 1'b0, glb_strobe);
    check_bit("SDO", 1'b0, sdo);
    spi_read(`REG_STATUS, rd);
    check_word("status", expected_status(hw_flags, 2'd0, 2'd0, 3'd0), rd);
    write_and_verify(`REG_DIRECT, `DMM_OUT_W, "direct", kept);
    write_and_verify(`REG_SA_PRECHARGE, `DMM_COUNT_W, "precharge", kept);
    write_and_verify(`REG_SA_SEQ_N, 3, "seq_n", seq_n);
    write_and_verify(`REG_SA_SEQ0, `DMM_SEQ_W, "seq0", kept);
    write_and_verify(`REG_SA_SEQ1, `DMM_SEQ_W, "seq1", kept);
    write_and_verify(`REG_SA_SEQ2, `DMM_SEQ_W, "seq2", kept);
    write_and_verify(`REG_SA_SEQ3, `DMM_SEQ_W, "seq3", kept);
    write_and_verify(`REG_ADC_APERTURE, `DMM_COUNT_W, "aperture", kept);
    spi_write(`REG_STATUS, $urandom());   // read only
    spi_read(`REG_STATUS, rd);
    check_word("status after write", expected_status(hw_flags, 2'd0, 2'd0, seq_n[2:0]), rd);
    finish_test("reset and register readback", errs);
  endtask

  task automatic direct_mode();
    int        errs, i;
    reg_word_t d, rd;
    out_vec_t  exp;
    errs = err_cnt;
    for (i = 0; i < 4; i++) begin
      d = $urandom();
      spi_write(`REG_DIRECT, d);
      exp             = out_vec_t'(d[`DMM_OUT_W-1:0]);
      exp.adc_reset_n = 1'b0;
      check_vec("direct outputs", exp, pins);
    end
    // short and long frames must be dropped
    send_frame({1'b1, `REG_DIRECT}, ~d, FRAME_BITS - 1, rd);
    check_vec("outputs after short frame", exp, pins);
    send_frame({1'b1, `REG_DIRECT}, ~d, FRAME_BITS + 1, rd);
    check_vec("outputs after long frame", exp, pins);
    spi_read(`REG_DIRECT, rd);
    check_word("direct readback", reg_word_t'(d[`DMM_OUT_W-1:0]), rd);
    finish_test("direct mode", errs);
  endtask

  task automatic spi_routing();
    int errs, m, c;
    errs = err_cnt;
    for (m = 0; m < 4; m++) begin
      spi_write(`REG_SPI_MUX, reg_word_t'(m));
      for (c = 0; c < 8; c++) begin
        sck     = c[2];   // ss stays high, bank ignores these
        sdi     = c[1];
        spi_cs2 = c[0];
        wait_cycles(1);
        check_bit("GLB_SPI_CLK", (m == 0) ? 1'b1 : c[2], glb_clk);
        check_bit("GLB_SPI_MOSI", (m == 0) ? 1'b1 : c[1], glb_mosi);
        check_bit("GLB_4094_STROBE_CTL", (m == 1) ? ~c[0] : 1'b0, glb_strobe);
        check_bit("SPI_DAC_SS", (m == 2) ? c[0] : 1'b1, dac_ss);
      end
      sck     = 1'b1;
      sdi     = 1'b0;
      spi_cs2 = 1'b1;
      wait_cycles(2);
    end
    spi_write(`REG_4094, 32'd1);
    check_bit("GLB_4094_OE_CTL", 1'b1, glb_oe);
    spi_write(`REG_SPI_MUX, 32'd0);
    spi_write(`REG_4094, 32'd0);
    check_bit("GLB_4094_OE_CTL", 1'b0, glb_oe);
    finish_test("spi routing", errs);
  endtask

  task automatic unused_modes_pattern();
    int        errs, i, n;
    mode_sel_t unused [5];
    logic      first, toggled;
    errs   = err_cnt;
    unused = '{3'd1, 3'd2, 3'd4, 3'd5, 3'd7};
    for (i = 0; i < 5; i++) begin
      spi_write(`REG_MODE, reg_word_t'(unused[i]));
      check_vec("outputs in unused mode", '0, pins);
    end
    spi_write(`REG_MODE, 32'd3);
    first   = leds[0];
    toggled = 1'b0;
    for (n = 0; n < (1 << (`DMM_PATTERN_SHIFT + 1)) && !toggled; n++) begin
      wait_cycles(1);
      if (leds[0] !== first)
        toggled = 1'b1;
    end
    if (!toggled) begin
      $display("t=%0t leds_o[0] never toggled in pattern mode", $time);
      err_cnt++;
    end
    spi_write(`REG_MODE, 32'd0);
    finish_test("unused modes and test pattern", errs);
  endtask

  task automatic wait_meas_pulse(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < PULSE_WAIT && !seen; n++) begin
      wait_cycles(1);
      check_bit("meas_complete_o", 1'b0, meas_complete);
      if (monitor[1] === 1'b1)
        seen = 1'b1;
    end
  endtask

  task automatic sequence_mock_adc();
    int        errs, k, idx;
    seq_word_t w [3];
    seq_idx_t  last_idx;
    out_vec_t  exp;
    reg_word_t rd;
    bit        seen;
    errs     = err_cnt;
    last_idx = '0;
    w[0]     = seq_word_t'($urandom());
    w[1]     = w[0];
    while (w[1] == w[0])
      w[1] = seq_word_t'($urandom());
    w[2] = w[0];
    while (w[2] == w[0] || w[2] == w[1])
      w[2] = seq_word_t'($urandom());
    spi_write(`REG_SA_PRECHARGE, 32'd20);
    spi_write(`REG_ADC_APERTURE, 32'd30);
    spi_write(`REG_SA_SEQ_N, 32'd3);
    spi_write(`REG_SA_SEQ0, reg_word_t'(w[0]));
    spi_write(`REG_SA_SEQ1, reg_word_t'(w[1]));
    spi_write(`REG_SA_SEQ2, reg_word_t'(w[2]));
    spi_write(`REG_MODE, 32'd6);
    arm = 1'b1;
    for (k = 0; k < 5; k++) begin
      idx = k % 3;            // seq0 seq1 seq2 seq0 seq1
      wait_meas_pulse(seen);
      if (!seen) begin
        $display("t=%0t no measurement pulse for word %0d", $time, k);
        err_cnt++;
        break;
      end
      last_idx    = seq_idx_t'(idx);
      exp         = '0;
      exp.azmux   = w[idx][3:0];
      exp.pc_sw   = w[idx][5:4];
      exp.monitor = {4'b0, last_idx, 1'b1, 1'b1};   // valid + adc out of reset
      exp.leds[0] = 1'b1;                           // armed
      check_vec("outputs at meas valid", exp, pins);
      wait_cycles(1);
      check_bit("monitor_o[1]", 1'b0, monitor[1]);  // single clk pulse
    end
    arm = 1'b0;
    wait_cycles(4);
    exp       = '0;           // idle, index back to 0
    exp.azmux = w[0][3:0];
    exp.pc_sw = w[0][5:4];
    check_vec("outputs after disarm", exp, pins);
    spi_read(`REG_STATUS, rd);
    check_idx("sample_idx_last", last_idx, seq_idx_t'(rd[17:16]));
    check_word("status", expected_status(hw_flags, 2'd0, last_idx, 3'd3), rd);
    spi_write(`REG_MODE, 32'd0);
    finish_test("sequence with mocked adc", errs);
  endtask

  ////////////////////
  // main + watchdog

  initial begin : main
    void'($urandom(SEED));
    err_cnt      = 0;
    tests_run    = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    sck          = 1'b1;   // idle high, frames start with a fall
    ss           = 1'b1;
    sdi          = 1'b0;
    spi_cs2      = 1'b1;
    arm          = 1'b0;
    hw_flags     = hw_flags_t'($urandom());
    wait_cycles(10);
    rst_n = 1'b1;
    wait_cycles(2);
    reset_and_readback();
    direct_mode();
    spi_routing();
    unused_modes_pattern();
    sequence_mock_adc();
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial begin : watchdog
    #(NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
    $display("watchdog expired after %0d clks, tests did not complete",
             NUM_TESTS * TEST_BUDGET);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/dmm_pkg.sv
rtl/spi_reg_bank.sv
rtl/adc_mock.sv
rtl/sequence_acq.sv
rtl/pin_mux.sv
rtl/dmm_top.sv
verif/tb_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
